//--- common/rv_core_pkg.sv
/* core widths, opcode and funct3 codes, ALU and format enums,
   and the format views of the instruction word */
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;

    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;
    localparam logic [2:0] f3_lb = 3'b000;
    localparam logic [2:0] f3_lh = 3'b001;
    localparam logic [2:0] f3_lw = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none  // unknown opcode, retires as a no-op
    } inst_fmt_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } inst_s_t;

    // branch offset bits are scattered across the word
    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_u_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

endpackage

`default_nettype wire

//--- hw/alu.sv
/* ten-operation integer ALU */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input wire [rv_core_pkg::xlen-1:0] a,
    input wire [rv_core_pkg::xlen-1:0] b,
    input wire rv_core_pkg::alu_op_t op,
    output logic [rv_core_pkg::xlen-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // shifts use the low 5 bits

    always_comb begin
        case (op)
            rv_core_pkg::alu_add: result = a + b;
            rv_core_pkg::alu_sub: result = a - b;
            rv_core_pkg::alu_sll: result = a << shamt;
            rv_core_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
            rv_core_pkg::alu_sltu: result = {31'b0, a < b};
            rv_core_pkg::alu_xor: result = a ^ b;
            rv_core_pkg::alu_srl: result = a >> shamt;
            rv_core_pkg::alu_sra: result = $signed(a) >>> shamt;
            rv_core_pkg::alu_or: result = a | b;
            rv_core_pkg::alu_and: result = a & b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
/* program counter, idle/wait fetch sequencer and instruction register */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input wire clk,
    input wire reset,
    input wire [rv_core_pkg::xlen-1:0] next_pc,
    output logic [rv_core_pkg::xlen-1:0] pc,
    output rv_core_pkg::inst_u inst,
    output logic [rv_core_pkg::xlen-1:0] imem_addr,
    input wire [rv_core_pkg::xlen-1:0] imem_rdata,
    output logic exec_valid
);

    typedef enum logic {
        st_idle,  // instruction being read
        st_wait   // instruction executing
    } fetch_state_t;

    fetch_state_t state;

    assign imem_addr = pc;
    assign exec_valid = (state == st_wait);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            pc <= rv_core_pkg::reset_pc;
        end else begin
            state <= (state == st_idle) ? st_wait : st_idle;
            if (exec_valid) pc <= next_pc;  // advance at end of execute
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle) inst <= imem_rdata;
    end

    // one instruction every two cycles
    assert property (@(posedge clk) disable iff (reset) exec_valid |=> !exec_valid);

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
/* instruction decode: format, immediate, register fields and ALU op */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input wire rv_core_pkg::inst_u inst,
    output rv_core_pkg::inst_fmt_t fmt,
    output logic [rv_core_pkg::xlen-1:0] imm,
    output rv_core_pkg::alu_op_t alu_op,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
    output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
    output logic [rv_core_pkg::reg_addr_w-1:0] rd
);

    logic [6:0] opcode;

    assign opcode = inst.r.opcode;
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd = inst.r.rd;

    always_comb begin
        case (opcode)
            rv_core_pkg::opc_op: fmt = rv_core_pkg::fmt_r;
            rv_core_pkg::opc_op_imm,
            rv_core_pkg::opc_load,
            rv_core_pkg::opc_jalr: fmt = rv_core_pkg::fmt_i;
            rv_core_pkg::opc_store: fmt = rv_core_pkg::fmt_s;
            rv_core_pkg::opc_branch: fmt = rv_core_pkg::fmt_b;
            rv_core_pkg::opc_lui,
            rv_core_pkg::opc_auipc: fmt = rv_core_pkg::fmt_u;
            rv_core_pkg::opc_jal: fmt = rv_core_pkg::fmt_j;
            default: fmt = rv_core_pkg::fmt_none;
        endcase
    end

    always_comb begin
        case (fmt)
            rv_core_pkg::fmt_i: imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            rv_core_pkg::fmt_s: imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            rv_core_pkg::fmt_b: imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            rv_core_pkg::fmt_u: imm = {inst.u.imm_31_12, 12'b0};
            rv_core_pkg::fmt_j: imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            default: imm = '0;
        endcase
    end

    // only OP and OP-IMM pick from funct3, everything else adds
    always_comb begin
        alu_op = rv_core_pkg::alu_add;
        if (opcode == rv_core_pkg::opc_op || opcode == rv_core_pkg::opc_op_imm) begin
            case (inst.r.funct3)
                3'b000: begin
                    if (fmt == rv_core_pkg::fmt_r && inst.r.funct7[5]) alu_op = rv_core_pkg::alu_sub;
                end
                3'b001: alu_op = rv_core_pkg::alu_sll;
                3'b010: alu_op = rv_core_pkg::alu_slt;
                3'b011: alu_op = rv_core_pkg::alu_sltu;
                3'b100: alu_op = rv_core_pkg::alu_xor;
                3'b101: alu_op = inst.r.funct7[5] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                3'b110: alu_op = rv_core_pkg::alu_or;
                default: alu_op = rv_core_pkg::alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
/* 32-entry register file, x0 hardwired to zero */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input wire clk,
    input wire reset,
    input wire we,
    input wire [rv_core_pkg::reg_addr_w-1:0] waddr,
    input wire [rv_core_pkg::xlen-1:0] wdata,
    input wire [rv_core_pkg::reg_addr_w-1:0] raddr1,
    input wire [rv_core_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_core_pkg::xlen-1:0] rdata1,
    output logic [rv_core_pkg::xlen-1:0] rdata2
);

    logic [rv_core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) regs[k] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
/* operand select, branch compare and next-pc selection */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input wire rv_core_pkg::inst_u inst,
    input wire rv_core_pkg::inst_fmt_t fmt,
    input wire [rv_core_pkg::xlen-1:0] imm,
    input wire rv_core_pkg::alu_op_t alu_op,
    input wire [rv_core_pkg::xlen-1:0] pc,
    input wire [rv_core_pkg::xlen-1:0] rdata1,
    input wire [rv_core_pkg::xlen-1:0] rdata2,
    output logic [rv_core_pkg::xlen-1:0] alu_result,
    output logic [rv_core_pkg::xlen-1:0] next_pc
);

    logic [rv_core_pkg::xlen-1:0] alu_a;
    logic [rv_core_pkg::xlen-1:0] alu_b;
    logic [rv_core_pkg::xlen-1:0] jump_target;
    logic jump_en;

    alu alu_inst (
        .a(alu_a),
        .b(alu_b),
        .op(alu_op),
        .result(alu_result)
    );

    always_comb begin
        alu_a = rdata1;
        alu_b = imm;
        jump_target = alu_result;
        jump_en = 1'b0;
        case (fmt)
            rv_core_pkg::fmt_r: alu_b = rdata2;
            rv_core_pkg::fmt_u: alu_a = (inst.u.opcode == rv_core_pkg::opc_lui) ? '0 : pc;
            rv_core_pkg::fmt_j: begin
                alu_a = pc;
                jump_en = 1'b1;
            end
            rv_core_pkg::fmt_i: begin
                if (inst.i.opcode == rv_core_pkg::opc_jalr) begin
                    jump_target = {alu_result[31:1], 1'b0};
                    jump_en = 1'b1;
                end
            end
            rv_core_pkg::fmt_b: begin
                alu_a = pc;  // target is pc + offset
                case (inst.b.funct3)
                    rv_core_pkg::f3_beq: jump_en = (rdata1 == rdata2);
                    rv_core_pkg::f3_bne: jump_en = (rdata1 != rdata2);
                    rv_core_pkg::f3_blt: jump_en = ($signed(rdata1) < $signed(rdata2));
                    rv_core_pkg::f3_bge: jump_en = ($signed(rdata1) >= $signed(rdata2));
                    rv_core_pkg::f3_bltu: jump_en = (rdata1 < rdata2);
                    rv_core_pkg::f3_bgeu: jump_en = (rdata1 >= rdata2);
                    default: jump_en = 1'b0;
                endcase
            end
            default: ;  // stores and unknown use rs1 + imm
        endcase
    end

    assign next_pc = jump_en ? jump_target : pc + 32'd4;

endmodule

`default_nettype wire

//--- hw/load_store_unit.sv
/* data port drive, store byte masks and load extension */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input wire rv_core_pkg::inst_u inst,
    input wire rv_core_pkg::inst_fmt_t fmt,
    input wire exec_valid,
    input wire [rv_core_pkg::xlen-1:0] alu_result,
    input wire [rv_core_pkg::xlen-1:0] rdata2,
    output logic [rv_core_pkg::xlen-1:0] load_data,
    output logic [rv_core_pkg::xlen-1:0] dmem_addr,
    output logic dmem_we,
    output logic [3:0] dmem_wmask,
    output logic [rv_core_pkg::xlen-1:0] dmem_wdata,
    input wire [rv_core_pkg::xlen-1:0] dmem_rdata
);

    assign dmem_addr = alu_result;
    assign dmem_wdata = rdata2;  // low-aligned, byte k goes to addr + k

    always_comb begin
        dmem_wmask = 4'h0;
        if (fmt == rv_core_pkg::fmt_s) begin
            case (inst.s.funct3)
                rv_core_pkg::f3_sb: dmem_wmask = 4'h1;
                rv_core_pkg::f3_sh: dmem_wmask = 4'h3;
                rv_core_pkg::f3_sw: dmem_wmask = 4'hf;
                default: dmem_wmask = 4'h0;
            endcase
        end
    end

    // illegal store widths never reach memory
    assign dmem_we = exec_valid && dmem_wmask != 4'h0;

    always_comb begin
        case (inst.i.funct3)
            rv_core_pkg::f3_lb: load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
            rv_core_pkg::f3_lh: load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
            rv_core_pkg::f3_lw: load_data = dmem_rdata;
            rv_core_pkg::f3_lbu: load_data = {24'b0, dmem_rdata[7:0]};
            rv_core_pkg::f3_lhu: load_data = {16'b0, dmem_rdata[15:0]};
            default: load_data = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/writeback_unit.sv
/* writeback source select and register write request */
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input wire rv_core_pkg::inst_u inst,
    input wire rv_core_pkg::inst_fmt_t fmt,
    input wire [rv_core_pkg::xlen-1:0] pc,
    input wire [rv_core_pkg::xlen-1:0] alu_result,
    input wire [rv_core_pkg::xlen-1:0] load_data,
    output logic rd_we,
    output logic [rv_core_pkg::xlen-1:0] rd_wdata
);

    always_comb begin
        rd_we = 1'b1;
        rd_wdata = alu_result;  // OP, OP-IMM, LUI, AUIPC
        case (fmt)
            rv_core_pkg::fmt_j: rd_wdata = pc + 32'd4;  // link
            rv_core_pkg::fmt_i: begin
                if (inst.i.opcode == rv_core_pkg::opc_jalr) rd_wdata = pc + 32'd4;
                else if (inst.i.opcode == rv_core_pkg::opc_load) rd_wdata = load_data;
            end
            rv_core_pkg::fmt_r, rv_core_pkg::fmt_u: ;
            default: begin
                rd_we = 1'b0;  // branch, store, unknown
                rd_wdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/rv_core_top.sv
/* RV32I core top: unit instances, register write enable, retire port */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input wire clk,
    input wire reset,
    output logic [rv_core_pkg::xlen-1:0] imem_addr,
    input wire [rv_core_pkg::xlen-1:0] imem_rdata,
    output logic [rv_core_pkg::xlen-1:0] dmem_addr,
    output logic dmem_we,
    output logic [3:0] dmem_wmask,
    output logic [rv_core_pkg::xlen-1:0] dmem_wdata,
    input wire [rv_core_pkg::xlen-1:0] dmem_rdata,
    output logic retire_valid,
    output logic [rv_core_pkg::xlen-1:0] retire_pc,
    output logic [rv_core_pkg::xlen-1:0] retire_next_pc,
    output logic retire_rd_we,
    output logic [rv_core_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_core_pkg::xlen-1:0] retire_rd_wdata
);

    rv_core_pkg::inst_u inst;
    rv_core_pkg::inst_fmt_t fmt;
    rv_core_pkg::alu_op_t alu_op;
    logic [rv_core_pkg::xlen-1:0] pc;
    logic [rv_core_pkg::xlen-1:0] next_pc;
    logic [rv_core_pkg::xlen-1:0] imm;
    logic [rv_core_pkg::xlen-1:0] rdata1;
    logic [rv_core_pkg::xlen-1:0] rdata2;
    logic [rv_core_pkg::xlen-1:0] alu_result;
    logic [rv_core_pkg::xlen-1:0] load_data;
    logic [rv_core_pkg::xlen-1:0] rd_wdata;
    logic [rv_core_pkg::reg_addr_w-1:0] rs1;
    logic [rv_core_pkg::reg_addr_w-1:0] rs2;
    logic [rv_core_pkg::reg_addr_w-1:0] rd;
    logic exec_valid;
    logic rd_we;

    fetch_unit fetch_unit_inst (
        .clk(clk),
        .reset(reset),
        .next_pc(next_pc),
        .pc(pc),
        .inst(inst),
        .imem_addr(imem_addr),
        .imem_rdata(imem_rdata),
        .exec_valid(exec_valid)
    );

    decode_unit decode_unit_inst (
        .inst(inst),
        .fmt(fmt),
        .imm(imm),
        .alu_op(alu_op),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd)
    );

    reg_file reg_file_inst (
        .clk(clk),
        .reset(reset),
        .we(rd_we && exec_valid),  // commit only at end of execute
        .waddr(rd),
        .wdata(rd_wdata),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    execute_unit execute_unit_inst (
        .inst(inst),
        .fmt(fmt),
        .imm(imm),
        .alu_op(alu_op),
        .pc(pc),
        .rdata1(rdata1),
        .rdata2(rdata2),
        .alu_result(alu_result),
        .next_pc(next_pc)
    );

    load_store_unit load_store_unit_inst (
        .inst(inst),
        .fmt(fmt),
        .exec_valid(exec_valid),
        .alu_result(alu_result),
        .rdata2(rdata2),
        .load_data(load_data),
        .dmem_addr(dmem_addr),
        .dmem_we(dmem_we),
        .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata)
    );

    writeback_unit writeback_unit_inst (
        .inst(inst),
        .fmt(fmt),
        .pc(pc),
        .alu_result(alu_result),
        .load_data(load_data),
        .rd_we(rd_we),
        .rd_wdata(rd_wdata)
    );

    // retire report, write request seen before the x0 filter
    assign retire_valid = exec_valid;
    assign retire_pc = pc;
    assign retire_next_pc = next_pc;
    assign retire_rd_we = rd_we;
    assign retire_rd = rd;
    assign retire_rd_wdata = rd_wdata;

    // stores only in the execute cycle, and only byte, half or word
    assert property (@(posedge clk) disable iff (reset)
        dmem_we |-> exec_valid && (dmem_wmask inside {4'h1, 4'h3, 4'hf}));

endmodule

`default_nettype wire

//--- sim/rv_ref_model.svh
/* reference RV32I model state and execution,
   random legal instruction generator */
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

logic [31:0] m_regs [32];
logic [7:0] m_mem [logic [31:0]];           // model data memory, bytes
rv_core_pkg::inst_u imem [logic [31:0]];    // fixed once generated

function automatic rv_core_pkg::inst_u gen_inst();
    rv_core_pkg::inst_u w;
    int kind;
    logic alt;
    w = $urandom();  // random fields, opcode and fixed bits forced below
    kind = $urandom_range(9);
    alt = 1'($urandom_range(1));
    case (kind)
        0, 1: begin
            w.r.opcode = rv_core_pkg::opc_op;
            w.r.funct7 = (alt && w.r.funct3 inside {3'd0, 3'd5}) ? 7'h20 : 7'h00;
        end
        2, 3: begin
            w.i.opcode = rv_core_pkg::opc_op_imm;
            if (w.r.funct3 == 3'd1) w.r.funct7 = 7'h00;
            if (w.r.funct3 == 3'd5) w.r.funct7 = alt ? 7'h20 : 7'h00;
        end
        4: begin
            w.u.opcode = alt ? rv_core_pkg::opc_lui : rv_core_pkg::opc_auipc;
            // values near reset_pc make later JALR land close to code
            if ($urandom_range(1) == 1) w.u.imm_31_12 = 20'h80000 | 20'($urandom_range(15));
        end
        5: begin
            if (alt) begin
                w.j.opcode = rv_core_pkg::opc_jal;
            end else begin
                w.i.opcode = rv_core_pkg::opc_jalr;
                w.i.funct3 = 3'd0;
            end
        end
        6, 9: begin
            w.b.opcode = rv_core_pkg::opc_branch;
            case ($urandom_range(5))
                0: w.b.funct3 = rv_core_pkg::f3_beq;
                1: w.b.funct3 = rv_core_pkg::f3_bne;
                2: w.b.funct3 = rv_core_pkg::f3_blt;
                3: w.b.funct3 = rv_core_pkg::f3_bge;
                4: w.b.funct3 = rv_core_pkg::f3_bltu;
                default: w.b.funct3 = rv_core_pkg::f3_bgeu;
            endcase
        end
        7: begin
            w.i.opcode = rv_core_pkg::opc_load;
            case ($urandom_range(4))
                0: w.i.funct3 = rv_core_pkg::f3_lb;
                1: w.i.funct3 = rv_core_pkg::f3_lh;
                2: w.i.funct3 = rv_core_pkg::f3_lw;
                3: w.i.funct3 = rv_core_pkg::f3_lbu;
                default: w.i.funct3 = rv_core_pkg::f3_lhu;
            endcase
            if (alt) w.i.rs1 = 5'd0;  // x0 base keeps loads near stores
        end
        default: begin
            w.s.opcode = rv_core_pkg::opc_store;
            w.s.funct3 = 3'($urandom_range(2));
            if (alt) w.s.rs1 = 5'd0;
        end
    endcase
    return w;
endfunction

// RV32I arithmetic by funct3, alt selects sub or sra
function automatic logic [31:0] arith(logic [2:0] f3, logic alt, logic [31:0] a,
                                      logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic [31:0] mem_word(logic [31:0] addr);
    logic [31:0] v;
    v = '0;  // never written reads as zero
    for (int k = 0; k < 4; k++) begin
        if (m_mem.exists(addr + 32'(k))) v[8*k +: 8] = m_mem[addr + 32'(k)];
    end
    return v;
endfunction

task automatic model_exec(input logic [31:0] pc, output logic [31:0] npc,
                          output logic we, output logic [4:0] rd, output logic [31:0] wd,
                          output logic st, output logic [31:0] saddr,
                          output logic [3:0] smask, output logic [31:0] sdata);
    rv_core_pkg::inst_u w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    logic [31:0] ld;
    logic take;
    w = imem[pc];
    a = m_regs[w.r.rs1];
    b = m_regs[w.r.rs2];
    i_imm = {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
    s_imm = {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
    b_imm = {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
    j_imm = {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
    npc = pc + 32'd4;
    we = 1'b0;
    rd = w.r.rd;
    wd = '0;
    st = 1'b0;
    saddr = '0;
    smask = '0;
    sdata = '0;
    take = 1'b0;
    case (w.r.opcode)
        rv_core_pkg::opc_op: begin
            we = 1'b1;
            wd = arith(w.r.funct3, w.r.funct7[5], a, b);
        end
        rv_core_pkg::opc_op_imm: begin
            we = 1'b1;
            wd = arith(w.r.funct3, w.r.funct3 == 3'd5 && w.r.funct7[5], a, i_imm);
        end
        rv_core_pkg::opc_lui: begin
            we = 1'b1;
            wd = {w.u.imm_31_12, 12'b0};
        end
        rv_core_pkg::opc_auipc: begin
            we = 1'b1;
            wd = pc + {w.u.imm_31_12, 12'b0};
        end
        rv_core_pkg::opc_jal: begin
            we = 1'b1;
            wd = pc + 32'd4;
            npc = pc + j_imm;
        end
        rv_core_pkg::opc_jalr: begin
            we = 1'b1;
            wd = pc + 32'd4;
            npc = (a + i_imm) & ~32'd1;
        end
        rv_core_pkg::opc_branch: begin
            case (w.b.funct3)
                rv_core_pkg::f3_beq: take = a == b;
                rv_core_pkg::f3_bne: take = a != b;
                rv_core_pkg::f3_blt: take = $signed(a) < $signed(b);
                rv_core_pkg::f3_bge: take = $signed(a) >= $signed(b);
                rv_core_pkg::f3_bltu: take = a < b;
                default: take = a >= b;
            endcase
            if (take) npc = pc + b_imm;
        end
        rv_core_pkg::opc_load: begin
            we = 1'b1;
            ld = mem_word(a + i_imm);
            case (w.i.funct3)
                rv_core_pkg::f3_lb: wd = {{24{ld[7]}}, ld[7:0]};
                rv_core_pkg::f3_lh: wd = {{16{ld[15]}}, ld[15:0]};
                rv_core_pkg::f3_lbu: wd = {24'b0, ld[7:0]};
                rv_core_pkg::f3_lhu: wd = {16'b0, ld[15:0]};
                default: wd = ld;
            endcase
        end
        rv_core_pkg::opc_store: begin
            st = 1'b1;
            saddr = a + s_imm;
            smask = (w.s.funct3 == rv_core_pkg::f3_sb) ? 4'h1 :
                    (w.s.funct3 == rv_core_pkg::f3_sh) ? 4'h3 : 4'hf;
            sdata = b;
            for (int k = 0; k < 4; k++) begin
                if (smask[k]) m_mem[saddr + 32'(k)] = b[8*k +: 8];
            end
        end
        default: ;
    endcase
    if (we && rd != 5'd0) m_regs[rd] = wd;
endtask

`endif

//--- sim/tb_rv_core.sv
/* testbench for the RV32I core: clock, reset, memory responders,
   model comparison and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int n_inst = 2000;
    localparam int clk_period = 4;
    localparam int watchdog_ns = (n_inst * 2 + 50) * clk_period;

    logic clk;
    logic reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic dmem_we;
    logic [3:0] dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_next_pc;
    logic retire_rd_we;
    logic [4:0] retire_rd;
    logic [31:0] retire_rd_wdata;

    logic [7:0] dut_mem [logic [31:0]];  // memory seen by the DUT
    logic [31:0] m_pc;
    int retired;
    int cyc;
    int post_reset;
    logic started;
    logic prev_valid;
    logic pend_st;
    logic [31:0] pend_addr;
    logic [31:0] pend_data;
    logic [3:0] pend_mask;

    `include "rv_ref_model.svh"

    rv_core_top rv_core_top_inst (
        .clk(clk),
        .reset(reset),
        .imem_addr(imem_addr),
        .imem_rdata(imem_rdata),
        .dmem_addr(dmem_addr),
        .dmem_we(dmem_we),
        .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata),
        .dmem_rdata(dmem_rdata),
        .retire_valid(retire_valid),
        .retire_pc(retire_pc),
        .retire_next_pc(retire_next_pc),
        .retire_rd_we(retire_rd_we),
        .retire_rd(retire_rd),
        .retire_rd_wdata(retire_rd_wdata)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_fail(input string what, input logic [31:0] got, input logic [31:0] exp);
        fail_run($sformatf("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_pc(input string what, input logic [rv_core_pkg::xlen-1:0] got,
                            input logic [rv_core_pkg::xlen-1:0] exp);
        if (got !== exp) value_fail(what, got, exp);
    endtask

    task automatic check_gpr_write(input logic got_we,
                                   input logic [rv_core_pkg::reg_addr_w-1:0] got_rd,
                                   input logic [rv_core_pkg::xlen-1:0] got_data,
                                   input logic exp_we,
                                   input logic [rv_core_pkg::reg_addr_w-1:0] exp_rd,
                                   input logic [rv_core_pkg::xlen-1:0] exp_data);
        if (got_we !== exp_we) value_fail("retire_rd_we", 32'(got_we), 32'(exp_we));
        if (exp_we) begin
            if (got_rd !== exp_rd) value_fail("retire_rd", 32'(got_rd), 32'(exp_rd));
            if (got_data !== exp_data) value_fail("retire_rd_wdata", got_data, exp_data);
        end
    endtask

    task automatic check_store(input logic got_we,
                               input logic [rv_core_pkg::xlen-1:0] got_addr,
                               input logic [3:0] got_mask,
                               input logic [rv_core_pkg::xlen-1:0] got_data,
                               input logic exp_we,
                               input logic [rv_core_pkg::xlen-1:0] exp_addr,
                               input logic [3:0] exp_mask,
                               input logic [rv_core_pkg::xlen-1:0] exp_data);
        logic [31:0] bytes;
        bytes = {{8{exp_mask[3]}}, {8{exp_mask[2]}}, {8{exp_mask[1]}}, {8{exp_mask[0]}}};
        if (got_we !== exp_we) value_fail("dmem_we", 32'(got_we), 32'(exp_we));
        if (exp_we) begin
            if (got_addr !== exp_addr) value_fail("dmem_addr", got_addr, exp_addr);
            if (got_mask !== exp_mask) value_fail("dmem_wmask", 32'(got_mask), 32'(exp_mask));
            // only enabled bytes matter
            if ((got_data & bytes) !== (exp_data & bytes))
                value_fail("dmem_wdata", got_data & bytes, exp_data & bytes);
        end
    endtask

    task automatic drive_mem();
        logic [31:0] v;
        if ($isunknown(imem_addr)) begin
            imem_rdata = '0;
        end else begin
            if (!imem.exists(imem_addr)) imem[imem_addr] = gen_inst();
            imem_rdata = imem[imem_addr];
        end
        v = '0;
        if (!$isunknown(dmem_addr)) begin
            for (int k = 0; k < 4; k++) begin
                if (dut_mem.exists(dmem_addr + 32'(k))) v[8*k +: 8] = dut_mem[dmem_addr + 32'(k)];
            end
        end
        dmem_rdata = v;
    endtask

    task automatic check_retire();
        logic [31:0] npc;
        logic we;
        logic [4:0] rd;
        logic [31:0] wd;
        logic st;
        logic [31:0] saddr;
        logic [3:0] smask;
        logic [31:0] sdata;
        post_reset++;
        if (!started && ((retire_valid === 1'b1) != (post_reset == 2)))
            fail_run("first instruction did not retire on the second cycle after reset");
        if (started && retire_valid === prev_valid)
            fail_run("retire_valid did not alternate between cycles");
        prev_valid = retire_valid;
        if (retire_valid !== 1'b1) begin
            if (dmem_we !== 1'b0) fail_run("dmem_we high outside the execute cycle");
            check_pc("imem_addr", imem_addr, m_pc);  // fetch address in idle
            return;
        end
        started = 1'b1;
        check_pc("retire_pc", retire_pc, m_pc);
        model_exec(m_pc, npc, we, rd, wd, st, saddr, smask, sdata);
        check_pc("retire_next_pc", retire_next_pc, npc);
        check_gpr_write(retire_rd_we, retire_rd, retire_rd_wdata, we, rd, wd);
        check_store(dmem_we, dmem_addr, dmem_wmask, dmem_wdata, st, saddr, smask, sdata);
        pend_st = dmem_we;
        pend_addr = dmem_addr;
        pend_mask = dmem_wmask;
        pend_data = dmem_wdata;
        m_pc = npc;
        retired++;
    endtask

    initial begin
        void'($urandom(32'hb394));
        reset = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        for (int k = 0; k < 32; k++) m_regs[k] = '0;
        m_pc = rv_core_pkg::reset_pc;
        retired = 0;
        cyc = 0;
        post_reset = 0;
        started = 1'b0;
        prev_valid = 1'b0;
        pend_st = 1'b0;
        while (retired < n_inst) begin
            @(negedge clk);
            cyc++;
            if (cyc == 3) reset = 1'b0;  // three rising edges in reset
            drive_mem();
            #1;
            if (reset) begin
                if (retire_valid !== 1'b0 || dmem_we !== 1'b0)
                    fail_run("retire_valid or dmem_we high during reset");
            end else begin
                check_retire();
            end
            @(posedge clk);
            if (pend_st) begin
                for (int k = 0; k < 4; k++) begin
                    if (pend_mask[k]) dut_mem[pend_addr + 32'(k)] = pend_data[8*k +: 8];
                end
                pend_st = 1'b0;
            end
        end
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        fail_run("watchdog expired before all instructions retired");
    end

endmodule

`default_nettype wire

//--- flist.f
common/rv_core_pkg.sv
hw/alu.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/load_store_unit.sv
hw/writeback_unit.sv
hw/rv_core_top.sv
+incdir+sim
sim/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project directory"
    exit 1
fi

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_core -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
